//--- exu_cases.txt
# name valid op funct3 src1 src2 imm pc | rd_wdata rd_wen next_pc taken (all hex)
# rd_wdata is checked only when rd_wen is expected high, next_pc only when valid
add          1 33 0 00000005 00000003 00000000 00001000 00000008 1 00001004 0
sub          1 33 0 00000005 00000007 00000020 00001004 fffffffe 1 00001008 0
slt          1 33 2 ffffffff 00000001 00000000 00001008 00000001 1 0000100c 0
sltu         1 33 3 ffffffff 00000001 00000000 0000100c 00000000 1 00001010 0
slti         1 13 2 fffffffe 00000000 ffffffff 00001010 00000001 1 00001014 0
sll          1 33 1 00000001 0000001f 00000000 00001014 80000000 1 00001018 0
srli         1 13 5 80000000 00000000 00000004 00001018 08000000 1 0000101c 0
srai         1 13 5 80000000 00000000 00000404 0000101c f8000000 1 00001020 0
sra          1 33 5 f0000000 00000008 00000020 00001020 fff00000 1 00001024 0
andi         1 13 7 ff00ff00 00000000 0f0f0f0f 00001024 0f000f00 1 00001028 0
lui          1 37 0 00000000 00000000 12345000 00001028 12345000 1 0000102c 0
auipc        1 17 0 00000000 00000000 00001000 00002000 00003000 1 00002004 0
beq_t        1 63 0 00000005 00000005 00000010 00003000 00000000 0 00003010 1
beq_n        1 63 0 00000005 00000006 00000010 00003000 00000000 0 00003004 0
bne_t        1 63 1 00000005 00000006 00000010 00003000 00000000 0 00003010 1
bne_n        1 63 1 00000005 00000005 00000010 00003000 00000000 0 00003004 0
blt_t        1 63 4 ffffffff 00000001 00000010 00003000 00000000 0 00003010 1
blt_n        1 63 4 00000001 ffffffff 00000010 00003000 00000000 0 00003004 0
bge_t        1 63 5 00000001 ffffffff 00000010 00003000 00000000 0 00003010 1
bge_n        1 63 5 ffffffff 00000001 00000010 00003000 00000000 0 00003004 0
bltu_t       1 63 6 00000001 ffffffff 00000010 00003000 00000000 0 00003010 1
bltu_n       1 63 6 ffffffff 00000001 00000010 00003000 00000000 0 00003004 0
bgeu_t       1 63 7 ffffffff 00000001 00000010 00003000 00000000 0 00003010 1
bgeu_n       1 63 7 00000001 ffffffff 00000010 00003000 00000000 0 00003004 0
jal          1 6f 0 00000000 00000000 00000100 00004000 00004004 1 00004100 0
jalr         1 67 0 00005001 00000000 00000010 00004100 00004104 1 00005010 0
sw           1 23 2 00000040 11223344 00000000 00005000 00000000 0 00005004 0
sb_off1      1 23 0 00000040 000000aa 00000001 00005004 00000000 0 00005008 0
sh_off2      1 23 1 00000040 00008001 00000002 00005008 00000000 0 0000500c 0
lb_off1      1 03 0 00000040 00000000 00000001 0000500c ffffffaa 1 00005010 0
lbu_off1     1 03 4 00000040 00000000 00000001 00005010 000000aa 1 00005014 0
lh_off2      1 03 1 00000040 00000000 00000002 00005014 ffff8001 1 00005018 0
lhu_off2     1 03 5 00000040 00000000 00000002 00005018 00008001 1 0000501c 0
lw           1 03 2 00000040 00000000 00000000 0000501c 8001aa44 1 00005020 0
lb_off0      1 03 0 00000040 00000000 00000000 00005020 00000044 1 00005024 0
csrrw_mtvec  1 73 1 00000200 00000000 00000305 00006000 00000100 1 00006004 0
csrrs_mtvec  1 73 2 00000030 00000000 00000305 00006004 00000200 1 00006008 0
csrr_mtvec   1 73 2 00000000 00000000 00000305 00006008 00000230 1 0000600c 0
ecall        1 73 0 00000000 00000000 00000000 00006100 00000000 0 00000230 0
csrr_mepc    1 73 2 00000000 00000000 00000341 00000230 00006100 1 00000234 0
csrr_mcause  1 73 2 00000000 00000000 00000342 00000234 0000000b 1 00000238 0
mret         1 73 0 00000000 00000000 00000302 00000238 00000000 0 00006100 0
ebreak       1 73 0 00000000 00000000 00000001 00006104 00000000 0 00000230 0
csrr_mcause3 1 73 2 00000000 00000000 00000342 00000230 00000003 1 00000234 0
idle_sw      0 23 2 00000040 00000000 00000000 00000000 00000000 0 00000000 0
idle_csrrw   0 73 1 00000000 00000000 00000305 00000000 00000000 0 00000000 0
idle_ecall   0 73 0 00000000 00000000 00000000 00000000 00000000 0 00000000 0
idle_bne     0 63 1 00000005 00000000 00000010 00000000 00000000 0 00000000 0
idle_add     0 33 0 00000001 00000000 00000000 00000000 00000000 0 00000000 0
lw_after     1 03 2 00000040 00000000 00000000 00007000 8001aa44 1 00007004 0
mtvec_after  1 73 2 00000000 00000000 00000305 00007004 00000230 1 00007008 0
mepc_after   1 73 2 00000000 00000000 00000341 00007008 00006104 1 0000700c 0

//--- filelist.f
+incdir+.
exu_isa_pkg.sv
exu_ctrl_pkg.sv
exu_decode.sv
exu_alu.sv
exu_lsu.sv
exu_csr.sv
exu_commit.sv
exu_top.sv
exu_assert.sv
tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - .
    files:
      - exu_isa_pkg.sv
      - exu_ctrl_pkg.sv
      - exu_decode.sv
      - exu_alu.sv
      - exu_lsu.sv
      - exu_csr.sv
      - exu_commit.sv
      - exu_top.sv
  - target: test
    files:
      - exu_assert.sv
      - tb_exu.sv

//--- tb_exu.sv
`default_nettype none

module tb_exu
    import exu_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD   = 10;
    localparam int    RESET_CYCLES = 16;
    localparam int    SEED         = 19181;
    localparam string CASE_FILE    = "exu_cases.txt";

    logic    clk = 1'b0;
    logic    rst_n;
    logic    valid;
    opcode_t op;
    funct3_t func;
    word_t   src1;
    word_t   src2;
    word_t   imm;
    word_t   pc;
    word_t   rd_wdata;
    logic    rd_wen;
    word_t   next_pc;
    logic    taken;

    int case_total = 0;
    bit counted    = 1'b0;    // watchdog starts once the cases are counted

    exu_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test, input string field,
                               input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s %s: expected %h, actual %h",
                                test, field, expected, actual));
        end
    endtask

    function automatic bit is_comment_line(input string line);
        byte c;
        if (line.len() == 0) begin
            return 1'b1;
        end
        c = line.getc(0);
        return (c == "#") || (c == "\n") || (c == "\r");
    endfunction

    task automatic count_cases(output int total);
        int    fd;
        string line;
        total = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("case file %s could not be opened", CASE_FILE));
        end
        while ($fgets(line, fd) != 0) begin
            if (!is_comment_line(line)) begin
                total++;
            end
        end
        $fclose(fd);
    endtask

    initial begin : watchdog
        wait (counted);
        #(case_total * 2 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        abort_run("timeout, the test steps did not finish in time");
    end

    initial begin : stimulus
        int          fd;
        int          fields;
        string       line;
        string       name;
        logic [31:0] f_valid;
        logic [31:0] f_op;
        logic [31:0] f_func;
        logic [31:0] f_src1;
        logic [31:0] f_src2;
        logic [31:0] f_imm;
        logic [31:0] f_pc;
        logic [31:0] exp_rd;
        logic [31:0] exp_wen;
        logic [31:0] exp_npc;
        logic [31:0] exp_taken;

        void'($urandom(SEED));
        rst_n = 1'b0;
        valid = 1'b0;
        op    = '0;
        func  = '0;
        src1  = '0;
        src2  = '0;
        imm   = '0;
        pc    = '0;

        count_cases(case_total);
        counted = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen(CASE_FILE, "r");
        while ($fgets(line, fd) != 0) begin
            if (is_comment_line(line)) begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, f_valid,
                             f_op, f_func, f_src1, f_src2, f_imm, f_pc,
                             exp_rd, exp_wen, exp_npc, exp_taken);
            if (fields != 12) begin
                abort_run($sformatf("malformed line in %s: %s", CASE_FILE, line));
            end
            if (f_valid[0] == 1'b0) begin
                f_src2 = $urandom();    // idle step, operands are noise
                f_pc   = $urandom();
            end

            @(posedge clk);
            valid <= f_valid[0];
            op    <= f_op[6:0];
            func  <= f_func[2:0];
            src1  <= f_src1;
            src2  <= f_src2;
            imm   <= f_imm;
            pc    <= f_pc;

            @(negedge clk);
            check_value(name, "rd_wen", exp_wen, word_t'(rd_wen));
            check_value(name, "taken", exp_taken, word_t'(taken));
            if (f_valid[0]) begin
                check_value(name, "next_pc", exp_npc, next_pc);
            end
            if (exp_wen[0]) begin
                check_value(name, "rd_wdata", exp_rd, rd_wdata);
            end
            if (u_dut.u_assert.fail_count != 0) begin
                abort_run($sformatf("a bound assertion failed by step %s", name));
            end
        end
        $fclose(fd);

        // one more edge so the last step is seen by the assertions
        @(posedge clk);
        @(negedge clk);
        if (u_dut.u_assert.fail_count != 0) begin
            abort_run("a bound assertion failed on the last step");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- exu_assert.sv
`default_nettype none

module exu_assert
    import exu_isa_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    valid,
    input opcode_t op,
    input logic    rd_wen,
    input word_t   next_pc,
    input logic    mem_wen,
    input logic    mem_ren
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;    // read by the testbench

    // a load and a store never decode together
    assert property (@(posedge clk) disable iff (!rst_n) !(mem_wen && mem_ren))
        else begin
            fail_count++;
            $error("mem_wen and mem_ren high together");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !valid |-> !rd_wen)
        else begin
            fail_count++;
            $error("rd_wen high while valid is low");
        end

    // only jalr may compute an odd-looking target
    assert property (@(posedge clk) disable iff (!rst_n)
                     (valid && op != OP_JALR) |-> (next_pc[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("next_pc not word aligned: %h", next_pc);
        end

endmodule

bind exu_top exu_assert u_assert (.*);

`default_nettype wire

//--- exu_top.sv
`default_nettype none

module exu_top
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid,
    input  opcode_t op,
    input  funct3_t func,
    input  word_t   src1,
    input  word_t   src2,
    input  word_t   imm,
    input  word_t   pc,
    output word_t   rd_wdata,
    output logic    rd_wen,
    output word_t   next_pc,
    output logic    taken
);

    word_t       upc;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_result;
    word_t       load_data;
    word_t       csr_rdata;
    word_t       trap_pc;
    logic        reg_wen;
    logic        jump;
    logic        mem_wen;
    logic        mem_ren;
    logic        csr_wen;
    logic        upc_ctl;
    logic        sub;
    logic        sign;
    logic        cmp_true;
    csr_ctl_t    csr_ctl;
    alu_ctl_t    alu_ctl;
    result_ctl_t result_ctl;
    wmask_t      wmask;
    load_ctl_t   load_ctl;

    exu_decode u_decode (.*);

    exu_alu u_alu (.*);

    // alu result is the effective address, src2 the store data
    exu_lsu u_lsu (.*, .addr(alu_result), .wdata(src2));

    exu_csr u_csr (.*, .csr_addr(imm[11:0]), .wdata(alu_result));

    exu_commit u_commit (.*);

endmodule

`default_nettype wire

//--- exu_commit.sv
`default_nettype none

module exu_commit
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  logic        valid,
    input  result_ctl_t result_ctl,
    input  logic        reg_wen,
    input  logic        jump,
    input  logic        upc_ctl,
    input  word_t       upc,
    input  word_t       pc,
    input  alu_ctl_t    alu_ctl,
    input  logic        cmp_true,
    input  word_t       alu_result,
    input  word_t       load_data,
    input  word_t       csr_rdata,
    input  word_t       trap_pc,
    output word_t       rd_wdata,
    output logic        rd_wen,
    output word_t       next_pc,
    output logic        taken
);

    logic is_branch;
    logic branch_hit;

    // b-type leaves both reg_wen and jump low
    assign is_branch  = !reg_wen && !jump && (alu_ctl inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE});
    assign branch_hit = is_branch && cmp_true;

    always_comb begin
        case (result_ctl)
            RES_LOAD: rd_wdata = load_data;
            RES_CSR:  rd_wdata = csr_rdata;    // old csr value
            default:  rd_wdata = alu_result;
        endcase
    end

    always_comb begin
        if (upc_ctl) begin
            next_pc = trap_pc;
        end else if (jump || branch_hit) begin
            next_pc = upc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign rd_wen = valid && reg_wen;
    assign taken  = valid && branch_hit;

endmodule

`default_nettype wire

//--- exu_csr.sv
`include "exu_settings.svh"

`default_nettype none

module exu_csr
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid,
    input  logic      csr_wen,
    input  csr_ctl_t  csr_ctl,
    input  csr_addr_t csr_addr,
    input  word_t     wdata,
    input  word_t     pc,
    output word_t     csr_rdata,
    output word_t     trap_pc
);

    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mcause;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= `EXU_MTVEC_RESET;
            mepc    <= '0;
            mcause  <= '0;
        end else if (valid && csr_wen) begin
            case (csr_ctl)
                CSR_WRITE: begin
                    case (csr_addr)
                        CSR_MSTATUS: mstatus <= wdata;
                        CSR_MTVEC:   mtvec   <= wdata;
                        CSR_MEPC:    mepc    <= wdata;
                        CSR_MCAUSE:  mcause  <= wdata;
                        default:     ;    // unknown csr ignored
                    endcase
                end
                CSR_ECALL: begin
                    mepc   <= pc;
                    mcause <= word_t'(11);    // ecall from m-mode
                end
                CSR_EBREAK: begin
                    mepc   <= pc;
                    mcause <= word_t'(3);     // breakpoint
                end
                default: ;    // mret only redirects
            endcase
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    assign trap_pc = (csr_ctl == CSR_MRET) ? mepc : mtvec;

endmodule

`default_nettype wire

//--- exu_lsu.sv
`include "exu_settings.svh"

`default_nettype none

module exu_lsu
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      valid,
    input  logic      mem_wen,
    input  logic      mem_ren,
    input  wmask_t    wmask,
    input  load_ctl_t load_ctl,
    input  word_t     addr,
    input  word_t     wdata,
    output word_t     load_data
);

    localparam int unsigned IDX_W = $clog2(`EXU_DMEM_WORDS);

    word_t            mem [`EXU_DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       offset;
    word_t            wdata_sh;
    wmask_t           wmask_sh;
    word_t            rdata_sh;
    word_t            load_ext;

    assign word_idx = addr[IDX_W+1:2];
    assign offset   = addr[1:0];
    assign wdata_sh = wdata << {offset, 3'b000};    // move data to its byte lane
    assign wmask_sh = wmask << offset;

    always_ff @(posedge clk) begin
        if (valid && mem_wen) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask_sh[i]) begin
                    mem[word_idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
                end
            end
        end
    end

    assign rdata_sh = mem[word_idx] >> {offset, 3'b000};    // addressed byte lands at bit 0

    always_comb begin
        case (load_ctl)
            3'b000:  load_ext = {{24{rdata_sh[7]}}, rdata_sh[7:0]};     // lb
            3'b001:  load_ext = {{16{rdata_sh[15]}}, rdata_sh[15:0]};   // lh
            3'b100:  load_ext = {24'b0, rdata_sh[7:0]};                 // lbu
            3'b101:  load_ext = {16'b0, rdata_sh[15:0]};                // lhu
            default: load_ext = rdata_sh;                               // lw
        endcase
    end

    assign load_data = mem_ren ? load_ext : '0;

endmodule

`default_nettype wire

//--- exu_alu.sv
`default_nettype none

module exu_alu
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  word_t    alu_a,
    input  word_t    alu_b,
    input  alu_ctl_t alu_ctl,
    input  logic     sub,
    input  logic     sign,
    output word_t    alu_result,
    output logic     cmp_true
);

    word_t b_eff;
    word_t sum;
    logic  carry;
    logic  overflow;
    logic  less;
    logic  zero;

    assign b_eff = sub ? ~alu_b : alu_b;
    assign {carry, sum} = {1'b0, alu_a} + {1'b0, b_eff} + {{$bits(word_t){1'b0}}, sub};

    // signed overflow of a + b_eff
    assign overflow = (alu_a[$bits(word_t)-1] == b_eff[$bits(word_t)-1])
                    && (sum[$bits(word_t)-1] != alu_a[$bits(word_t)-1]);

    // no carry out of a - b means a < b unsigned
    assign less = sign ? (sum[$bits(word_t)-1] ^ overflow) : ~carry;
    assign zero = (sum == '0);

    always_comb begin
        case (alu_ctl)
            ALU_BEQ: cmp_true = zero;
            ALU_BNE: cmp_true = ~zero;
            ALU_BLT: cmp_true = less;
            ALU_BGE: cmp_true = ~less;
            default: cmp_true = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_ctl)
            ALU_XOR: alu_result = alu_a ^ alu_b;
            ALU_OR:  alu_result = alu_a | alu_b;
            ALU_AND: alu_result = alu_a & alu_b;
            ALU_SLL: alu_result = alu_a << alu_b[4:0];
            ALU_SRL: alu_result = alu_a >> alu_b[4:0];
            ALU_SRA: alu_result = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_SET: alu_result = {{($bits(word_t)-1){1'b0}}, less};
            default: alu_result = sum;    // add, sub and branch difference
        endcase
    end

endmodule

`default_nettype wire

//--- exu_decode.sv
`default_nettype none

module exu_decode
    import exu_isa_pkg::*, exu_ctrl_pkg::*;
(
    input  opcode_t     op,
    input  funct3_t     func,
    input  word_t       src1,
    input  word_t       src2,
    input  word_t       imm,
    input  word_t       pc,
    input  word_t       csr_rdata,
    output word_t       upc,
    output word_t       alu_a,
    output word_t       alu_b,
    output logic        reg_wen,
    output logic        jump,
    output logic        mem_wen,
    output logic        mem_ren,
    output logic        csr_wen,
    output csr_ctl_t    csr_ctl,
    output alu_ctl_t    alu_ctl,
    output result_ctl_t result_ctl,
    output logic        upc_ctl,
    output logic        sub,
    output logic        sign,
    output wmask_t      wmask,
    output load_ctl_t   load_ctl
);

    always_comb begin
        upc        = pc + imm;    // jal and branch target
        alu_a      = src1;
        alu_b      = src2;
        reg_wen    = 1'b1;
        jump       = 1'b0;
        mem_wen    = 1'b0;
        mem_ren    = 1'b0;
        csr_wen    = 1'b0;
        csr_ctl    = CSR_NONE;
        alu_ctl    = ALU_ADD;
        result_ctl = RES_ALU;
        upc_ctl    = 1'b0;
        sub        = 1'b0;
        sign       = 1'b0;
        wmask      = 4'b0000;
        load_ctl   = 3'b000;

        case (op)
            OP_IMM: begin
                alu_b = imm;
                case (func)
                    3'b010: begin    // slti
                        alu_ctl = ALU_SET;
                        sub     = 1'b1;
                        sign    = 1'b1;
                    end
                    3'b011: begin    // sltiu
                        alu_ctl = ALU_SET;
                        sub     = 1'b1;
                    end
                    3'b100: alu_ctl = ALU_XOR;
                    3'b110: alu_ctl = ALU_OR;
                    3'b111: alu_ctl = ALU_AND;
                    3'b001: alu_ctl = ALU_SLL;
                    3'b101: alu_ctl = imm[10] ? ALU_SRA : ALU_SRL;    // imm[10] is funct7[5]
                    default: alu_ctl = ALU_ADD;    // addi
                endcase
            end
            OP_LOAD: begin
                alu_b      = imm;
                mem_ren    = 1'b1;
                result_ctl = RES_LOAD;
                load_ctl   = func;
            end
            OP_REG: begin
                // imm carries funct7 on register ops
                case (func)
                    3'b000: sub = imm[5];    // add or sub
                    3'b001: alu_ctl = ALU_SLL;
                    3'b010: begin    // slt
                        alu_ctl = ALU_SET;
                        sub     = 1'b1;
                        sign    = 1'b1;
                    end
                    3'b011: begin    // sltu
                        alu_ctl = ALU_SET;
                        sub     = 1'b1;
                    end
                    3'b100: alu_ctl = ALU_XOR;
                    3'b101: alu_ctl = imm[5] ? ALU_SRA : ALU_SRL;
                    3'b110: alu_ctl = ALU_OR;
                    default: alu_ctl = ALU_AND;
                endcase
            end
            OP_AUIPC: begin
                alu_a = pc;
                alu_b = imm;
            end
            OP_JAL, OP_JALR: begin
                alu_a = pc;
                alu_b = 32'd4;    // link address
                jump  = 1'b1;
                if (op == OP_JALR) begin
                    upc = (src1 + imm) & ~32'd1;
                end
            end
            OP_LUI: begin
                alu_a = '0;
                alu_b = imm;
            end
            OP_STORE: begin
                reg_wen = 1'b0;
                alu_b   = imm;
                mem_wen = 1'b1;
                case (func)
                    3'b000:  wmask = 4'b0001;    // sb
                    3'b001:  wmask = 4'b0011;    // sh
                    default: wmask = 4'b1111;
                endcase
            end
            OP_BRANCH: begin
                reg_wen = 1'b0;
                sub     = 1'b1;
                case (func)
                    3'b000:  alu_ctl = ALU_BEQ;
                    3'b001:  alu_ctl = ALU_BNE;
                    3'b100:  begin
                        alu_ctl = ALU_BLT;
                        sign    = 1'b1;
                    end
                    3'b101:  begin
                        alu_ctl = ALU_BGE;
                        sign    = 1'b1;
                    end
                    3'b110:  alu_ctl = ALU_BLT;    // bltu
                    3'b111:  alu_ctl = ALU_BGE;    // bgeu
                    default: alu_ctl = ALU_ADD;    // never taken
                endcase
            end
            OP_SYSTEM: begin
                result_ctl = RES_CSR;
                case (func)
                    3'b000: begin
                        // mret 0x302, ecall 0x000, ebreak 0x001
                        if (imm[1]) begin
                            csr_ctl = CSR_MRET;
                        end else if (!imm[0]) begin
                            csr_ctl = CSR_ECALL;
                        end else begin
                            csr_ctl = CSR_EBREAK;
                        end
                        reg_wen = 1'b0;
                        csr_wen = 1'b1;
                        jump    = 1'b1;
                        upc_ctl = 1'b1;
                    end
                    3'b001: begin    // csrrw, rs1 passes through
                        alu_b   = '0;
                        csr_wen = 1'b1;
                        csr_ctl = CSR_WRITE;
                    end
                    3'b010: begin    // csrrs
                        alu_b   = csr_rdata;
                        alu_ctl = ALU_OR;
                        csr_wen = 1'b1;
                        csr_ctl = CSR_WRITE;
                    end
                    default: reg_wen = 1'b0;
                endcase
            end
            default: reg_wen = 1'b0;    // unknown opcode acts as nop
        endcase
    end

endmodule

`default_nettype wire

//--- exu_ctrl_pkg.sv
`default_nettype none

package exu_ctrl_pkg;

    typedef logic [3:0] alu_ctl_t;
    typedef logic [1:0] result_ctl_t;
    typedef logic [2:0] csr_ctl_t;
    typedef logic [3:0] wmask_t;       // one bit per byte lane
    typedef logic [2:0] load_ctl_t;    // funct3 of the load

    localparam alu_ctl_t ALU_ADD = 4'b0000;
    localparam alu_ctl_t ALU_XOR = 4'b0001;
    localparam alu_ctl_t ALU_OR  = 4'b0010;
    localparam alu_ctl_t ALU_AND = 4'b0011;
    localparam alu_ctl_t ALU_SLL = 4'b0100;
    localparam alu_ctl_t ALU_SRL = 4'b0101;
    localparam alu_ctl_t ALU_SRA = 4'b0110;
    localparam alu_ctl_t ALU_BEQ = 4'b1000;    // branch compares share 2'b10 on top
    localparam alu_ctl_t ALU_BNE = 4'b1001;
    localparam alu_ctl_t ALU_BLT = 4'b1010;
    localparam alu_ctl_t ALU_BGE = 4'b1011;
    localparam alu_ctl_t ALU_SET = 4'b1100;

    localparam result_ctl_t RES_ALU  = 2'd0;
    localparam result_ctl_t RES_LOAD = 2'd1;
    localparam result_ctl_t RES_CSR  = 2'd2;

    localparam csr_ctl_t CSR_NONE   = 3'b000;
    localparam csr_ctl_t CSR_MRET   = 3'b001;
    localparam csr_ctl_t CSR_ECALL  = 3'b010;
    localparam csr_ctl_t CSR_EBREAK = 3'b011;
    localparam csr_ctl_t CSR_WRITE  = 3'b100;

endpackage

`default_nettype wire

//--- exu_isa_pkg.sv
`include "exu_settings.svh"

`default_nettype none

package exu_isa_pkg;

    typedef logic [`EXU_XLEN-1:0] word_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [11:0]          csr_addr_t;    // low 12 bits of imm

    // major opcodes
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // machine csrs held by the stage
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

endpackage

`default_nettype wire

//--- exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath width, fixed by rv32i
`define EXU_XLEN 32

// data memory depth in 32-bit words
`define EXU_DMEM_WORDS 256

// trap vector after reset
`define EXU_MTVEC_RESET 32'h0000_0100

`endif
